//--- bench/lpc_golden.txt
# W addr data = test write, R addr data = test read expect, N = idle, G = random idle gap
# O op a b d = command (op hex 0 add .. B norm_l), E addr data ovf = expected writeback
W 010 00007FFF
W 011 00000001
W 012 FFFF8000
W 013 FFFFFFFF
W 014 7FFFFFFF
W 015 80000000
W 016 00004000
W 017 40000000
W 018 00000000
W 019 00000004
W 01A FFFFFFFC
W 01B 00000028
W 01C 12345678
W 01D 0000001F
W 01E 7FFF8000
W 01F 80008000
R 010 00007FFF
R 015 80000000
R 01E 7FFF8000
R 01A FFFFFFFC
# 16-bit add, sub and mult
O 0 010 011 100
E 100 00007FFF 1
O 0 012 013 101
E 101 FFFF8000 1
O 0 016 011 102
E 102 00004001 0
G
O 1 012 011 103
E 103 FFFF8000 1
O 1 010 013 104
E 104 00007FFF 1
O 1 011 016 105
E 105 FFFFC001 0
G
O 2 012 012 106
E 106 00007FFF 1
O 2 016 016 107
E 107 00002000 0
O 2 010 012 108
E 108 FFFF8001 0
G
# 32-bit add, sub, mult and mac near the limits
O 3 014 011 109
E 109 7FFFFFFF 1
O 3 015 013 10A
E 10A 80000000 1
O 3 017 013 10B
E 10B 3FFFFFFF 0
O 4 015 011 10C
E 10C 80000000 1
O 4 014 013 10D
E 10D 7FFFFFFF 1
O 4 018 014 10E
E 10E 80000001 0
G
O 5 012 012 10F
E 10F 7FFFFFFF 1
O 5 010 012 110
E 110 80010000 0
O 5 016 013 111
E 111 FFFF8000 0
O 6 01E 015 112
E 112 80000000 1
O 6 01E 018 113
E 113 80010000 0
O 6 01F 018 114
E 114 7FFFFFFF 1
O 6 01E 014 115
E 115 0000FFFF 0
G
# Shifts, negate, abs and norm_l
O 9 016 019 116
E 116 00040000 0
O 9 01C 019 117
E 117 7FFFFFFF 1
O 9 01C 01A 118
E 118 01234567 0
O 9 015 01B 119
E 119 80000000 1
O A 01C 019 11A
E 11A 01234567 0
O A 013 01B 11B
E 11B FFFFFFFF 0
O A 015 01D 11C
E 11C FFFFFFFF 0
O A 016 01A 11D
E 11D 00040000 0
O A 017 01A 11E
E 11E 7FFFFFFF 1
G
O 7 015 018 11F
E 11F 7FFFFFFF 1
O 7 011 018 120
E 120 FFFFFFFF 0
O 8 015 018 121
E 121 7FFFFFFF 1
O 8 013 018 122
E 122 00000001 0
O B 018 018 123
E 123 00000000 0
O B 013 018 124
E 124 0000001F 0
O B 011 018 125
E 125 0000001E 0
O B 017 018 126
E 126 00000000 0
G
# Back to back, the last two read results written four cycles earlier
O 3 016 011 130
E 130 00004001 0
O 3 017 016 131
E 131 40004000 0
O 0 011 011 132
E 132 00000002 0
O 5 016 016 133
E 133 20000000 0
O 3 130 011 134
E 134 00004002 0
O 4 131 011 135
E 135 40003FFF 0
N
N
N
N
R 134 00004002
R 135 40003FFF
R 130 00004001
R 133 20000000
R 100 00007FFF

//--- list.f
+incdir+source
source/lpc_pkg.sv
source/scratch_memory.sv
source/op_issue.sv
source/basic_op_alu.sv
source/shift_norm_stage.sv
source/lpc_datapath_top.sv
bench/tb_lpc_datapath.sv

//--- run.sh
#!/bin/sh
# Build and run the LPC datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f \
	--top-module tb_lpc_datapath -Mdir obj_dir -o tb_lpc_datapath
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build returned status $status"
	exit $status
fi

./obj_dir/tb_lpc_datapath
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation returned status $status"
	exit $status
fi

exit 0

//--- bench/tb_lpc_datapath.sv
`default_nettype none

module tb_lpc_datapath;
	timeunit 1ns;
	timeprecision 1ps;

	// Cycles from driving a command to checking its writeback
	localparam int WB_LATENCY   = 3;
	localparam int RESET_CYCLES = 16;

	logic                clock;
	logic                i_rst_n;
	logic                i_op_valid;
	lpc_pkg::basic_op_e  i_opcode;
	lpc_pkg::addr_t      i_addr_a;
	lpc_pkg::addr_t      i_addr_b;
	lpc_pkg::addr_t      i_addr_d;
	logic                i_test_mode;
	logic                i_test_we;
	lpc_pkg::addr_t      i_test_addr;
	lpc_pkg::word_t      i_test_wdata;
	wire lpc_pkg::word_t o_test_rdata;
	wire                 o_wb_valid;
	wire lpc_pkg::addr_t o_wb_addr;
	wire lpc_pkg::word_t o_wb_data;
	wire                 o_wb_ovf;

	string          records [$];
	lpc_pkg::addr_t exp_addr_q [$];
	lpc_pkg::word_t exp_data_q [$];
	logic           exp_ovf_q [$];
	int             issue_q [$];
	int             cycle_count = 0;
	int             cycle_limit = 0;
	bit             cmd_seen;

	lpc_datapath_top u_dut (
		.clock        (clock),
		.i_rst_n      (i_rst_n),
		.i_op_valid   (i_op_valid),
		.i_opcode     (i_opcode),
		.i_addr_a     (i_addr_a),
		.i_addr_b     (i_addr_b),
		.i_addr_d     (i_addr_d),
		.i_test_mode  (i_test_mode),
		.i_test_we    (i_test_we),
		.i_test_addr  (i_test_addr),
		.i_test_wdata (i_test_wdata),
		.o_test_rdata (o_test_rdata),
		.o_wb_valid   (o_wb_valid),
		.o_wb_addr    (o_wb_addr),
		.o_wb_data    (o_wb_data),
		.o_wb_ovf     (o_wb_ovf)
	);

	always #20 clock = ~clock;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic drive_idle();
		i_op_valid  = 1'b0;
		i_test_mode = 1'b0;
		i_test_we   = 1'b0;
	endtask

	// Lines starting with '#' and blank lines are skipped
	task automatic load_golden();
		int    fd;
		int    code;
		string line;
		fd = $fopen("bench/lpc_golden.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the golden file bench/lpc_golden.txt");
			abort_run();
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				code = $fgets(line, fd);
				if (code > 0 && line.getc(0) != "#" && line.getc(0) != "\n")
				begin
					records.push_back(line);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_quiet_outputs();
		assert (o_wb_valid == 1'b0) else
		begin
			$display("[FAIL] %0t o_wb_valid expected 0 actual %b", $time, o_wb_valid);
			abort_run();
		end
		assert (o_wb_ovf == 1'b0) else
		begin
			$display("[FAIL] %0t o_wb_ovf expected 0 actual %b", $time, o_wb_ovf);
			abort_run();
		end
	endtask

	task automatic check_field_count(input int got, input int want, input string line);
		assert (got == want) else
		begin
			$display("Malformed golden record, expected %0d fields in: %s", want, line);
			abort_run();
		end
	endtask

	//////////////////////////////
	// Record player
	//////////////////////////////

	task automatic run_record(input string line);
		int             n;
		int unsigned    gap;
		logic [3:0]     op_val;
		lpc_pkg::addr_t a;
		lpc_pkg::addr_t b;
		lpc_pkg::addr_t d;
		lpc_pkg::word_t data;
		logic           ovf;
		case (line.getc(0))
			"W":
			begin
				n = $sscanf(line, "W %h %h", a, data);
				check_field_count(n, 2, line);
				i_op_valid   = 1'b0;
				i_test_mode  = 1'b1;
				i_test_we    = 1'b1;
				i_test_addr  = a;
				i_test_wdata = data;
				@(negedge clock);
			end
			"R":
			begin
				n = $sscanf(line, "R %h %h", a, data);
				check_field_count(n, 2, line);
				i_op_valid  = 1'b0;
				i_test_mode = 1'b1;
				i_test_we   = 1'b0;
				i_test_addr = a;
				@(negedge clock);
				// Word shows up one cycle after the address is sampled
				assert (o_test_rdata == data) else
				begin
					$display("[FAIL] %0t o_test_rdata expected %h actual %h",
						$time, data, o_test_rdata);
					abort_run();
				end
			end
			"O":
			begin
				n = $sscanf(line, "O %h %h %h %h", op_val, a, b, d);
				check_field_count(n, 4, line);
				i_test_mode = 1'b0;
				i_test_we   = 1'b0;
				i_op_valid  = 1'b1;
				i_opcode    = lpc_pkg::basic_op_e'(op_val);
				i_addr_a    = a;
				i_addr_b    = b;
				i_addr_d    = d;
				issue_q.push_back(cycle_count);
				cmd_seen = 1'b1;
				@(negedge clock);
			end
			"E":
			begin
				n = $sscanf(line, "E %h %h %h", d, data, ovf);
				check_field_count(n, 3, line);
				exp_addr_q.push_back(d);
				exp_data_q.push_back(data);
				exp_ovf_q.push_back(ovf);
			end
			"N":
			begin
				drive_idle();
				@(negedge clock);
			end
			"G":
			begin
				// Random spacing between independent commands
				gap = $urandom_range(3, 0);
				drive_idle();
				repeat (gap) @(negedge clock);
			end
			default:
			begin
				$display("Unknown record type in golden file: %s", line);
				abort_run();
			end
		endcase
	endtask

	//////////////////////////////
	// Writeback monitor
	//////////////////////////////

	task automatic check_writeback();
		lpc_pkg::addr_t exp_addr;
		lpc_pkg::word_t exp_data;
		logic           exp_ovf;
		int             issued;
		if (exp_data_q.size() == 0 || issue_q.size() == 0)
		begin
			$display("Writeback to address %h at %0t has no expected record", o_wb_addr, $time);
			abort_run();
		end
		else
		begin
			exp_addr = exp_addr_q.pop_front();
			exp_data = exp_data_q.pop_front();
			exp_ovf  = exp_ovf_q.pop_front();
			issued   = issue_q.pop_front();
			assert (o_wb_addr == exp_addr) else
			begin
				$display("[FAIL] %0t o_wb_addr expected %h actual %h", $time, exp_addr, o_wb_addr);
				abort_run();
			end
			assert (o_wb_data == exp_data) else
			begin
				$display("[FAIL] %0t o_wb_data expected %h actual %h", $time, exp_data, o_wb_data);
				abort_run();
			end
			assert (o_wb_ovf == exp_ovf) else
			begin
				$display("[FAIL] %0t o_wb_ovf expected %b actual %b", $time, exp_ovf, o_wb_ovf);
				abort_run();
			end
			// Issue stamp and this check both fall on a falling edge
			assert (cycle_count - issued == WB_LATENCY) else
			begin
				$display("[FAIL] %0t o_wb_valid latency expected %0d actual %0d",
					$time, WB_LATENCY, cycle_count - issued);
				abort_run();
			end
		end
	endtask

	always @(negedge clock)
	begin
		if (i_rst_n && o_wb_valid)
			check_writeback();
	end

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("Timeout after %0d cycles with writebacks still outstanding", cycle_limit);
			abort_run();
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		clock        = 1'b0;
		i_rst_n      = 1'b0;
		i_op_valid   = 1'b0;
		i_opcode     = lpc_pkg::OP_ADD;
		i_addr_a     = '0;
		i_addr_b     = '0;
		i_addr_d     = '0;
		i_test_mode  = 1'b0;
		i_test_we    = 1'b0;
		i_test_addr  = '0;
		i_test_wdata = '0;
		cmd_seen     = 1'b0;
		void'($urandom(73923));
		load_golden();
		cycle_limit = 4 * records.size() + 100;

		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		i_rst_n = 1'b1;

		foreach (records[i])
		begin
			if (!cmd_seen)
				check_quiet_outputs();
			run_record(records[i]);
		end

		// Drain the pipeline, then look for stray writebacks
		drive_idle();
		while (exp_data_q.size() != 0)
			@(negedge clock);
		repeat (WB_LATENCY + 1) @(negedge clock);

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/lpc_datapath_top.sv
`default_nettype none

module lpc_datapath_top (
	input  wire                     clock,
	input  wire                     i_rst_n,
	// Command
	input  wire                     i_op_valid,
	input  wire lpc_pkg::basic_op_e i_opcode,
	input  wire lpc_pkg::addr_t     i_addr_a,
	input  wire lpc_pkg::addr_t     i_addr_b,
	input  wire lpc_pkg::addr_t     i_addr_d,
	// Test port
	input  wire                     i_test_mode,
	input  wire                     i_test_we,
	input  wire lpc_pkg::addr_t     i_test_addr,
	input  wire lpc_pkg::word_t     i_test_wdata,
	output wire lpc_pkg::word_t     o_test_rdata,
	// Writeback strobe
	output wire                     o_wb_valid,
	output wire lpc_pkg::addr_t     o_wb_addr,
	output wire lpc_pkg::word_t     o_wb_data,
	output wire                     o_wb_ovf
);

	wire lpc_pkg::addr_t     raddr_a;
	wire lpc_pkg::addr_t     raddr_b;
	wire lpc_pkg::word_t     rdata_a;
	wire lpc_pkg::word_t     rdata_b;
	wire                     mem_we;
	wire lpc_pkg::addr_t     mem_waddr;
	wire lpc_pkg::word_t     mem_wdata;

	wire                     s1_valid;
	wire lpc_pkg::basic_op_e s1_opcode;
	wire lpc_pkg::addr_t     s1_addr_d;

	wire                     s2_valid;
	wire lpc_pkg::basic_op_e s2_opcode;
	wire lpc_pkg::addr_t     s2_addr_d;
	wire lpc_pkg::word_t     s2_result;
	wire                     s2_ovf;
	wire lpc_pkg::word_t     s2_opnd_a;
	wire lpc_pkg::word_t     s2_opnd_b;

	// Test mode owns the write port
	assign mem_we       = i_test_mode ? i_test_we    : o_wb_valid;
	assign mem_waddr    = i_test_mode ? i_test_addr  : o_wb_addr;
	assign mem_wdata    = i_test_mode ? i_test_wdata : o_wb_data;
	assign o_test_rdata = rdata_a;

	op_issue u_issue (
		.clock       (clock),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_opcode    (i_opcode),
		.i_addr_a    (i_addr_a),
		.i_addr_b    (i_addr_b),
		.i_addr_d    (i_addr_d),
		.i_test_mode (i_test_mode),
		.i_test_addr (i_test_addr),
		.i_wb_valid  (o_wb_valid),
		.o_raddr_a   (raddr_a),
		.o_raddr_b   (raddr_b),
		.o_valid     (s1_valid),
		.o_opcode    (s1_opcode),
		.o_addr_d    (s1_addr_d)
	);

	scratch_memory u_mem (
		.clock     (clock),
		.i_we      (mem_we),
		.i_waddr   (mem_waddr),
		.i_wdata   (mem_wdata),
		.i_raddr_a (raddr_a),
		.i_raddr_b (raddr_b),
		.o_rdata_a (rdata_a),
		.o_rdata_b (rdata_b)
	);

	// Operands arrive from the RAM aligned with the stage 1 command
	basic_op_alu u_alu (
		.clock    (clock),
		.i_rst_n  (i_rst_n),
		.i_valid  (s1_valid),
		.i_opcode (s1_opcode),
		.i_addr_d (s1_addr_d),
		.i_opnd_a (rdata_a),
		.i_opnd_b (rdata_b),
		.o_valid  (s2_valid),
		.o_opcode (s2_opcode),
		.o_addr_d (s2_addr_d),
		.o_result (s2_result),
		.o_ovf    (s2_ovf),
		.o_opnd_a (s2_opnd_a),
		.o_opnd_b (s2_opnd_b)
	);

	shift_norm_stage u_shift (
		.clock      (clock),
		.i_rst_n    (i_rst_n),
		.i_valid    (s2_valid),
		.i_opcode   (s2_opcode),
		.i_addr_d   (s2_addr_d),
		.i_result   (s2_result),
		.i_ovf      (s2_ovf),
		.i_opnd_a   (s2_opnd_a),
		.i_opnd_b   (s2_opnd_b),
		.o_wb_valid (o_wb_valid),
		.o_wb_addr  (o_wb_addr),
		.o_wb_data  (o_wb_data),
		.o_wb_ovf   (o_wb_ovf)
	);

endmodule

`default_nettype wire

//--- source/shift_norm_stage.sv
`default_nettype none

module shift_norm_stage (
	input  wire                     clock,
	input  wire                     i_rst_n,
	input  wire                     i_valid,
	input  wire lpc_pkg::basic_op_e i_opcode,
	input  wire lpc_pkg::addr_t     i_addr_d,
	input  wire lpc_pkg::word_t     i_result,
	input  wire                     i_ovf,
	input  wire lpc_pkg::word_t     i_opnd_a,
	input  wire lpc_pkg::word_t     i_opnd_b,
	output logic                    o_wb_valid,
	output lpc_pkg::addr_t          o_wb_addr,
	output lpc_pkg::word_t          o_wb_data,
	output logic                    o_wb_ovf
);

	//////////////////////////////
	// Shift helpers
	//////////////////////////////

	// Arithmetic right shift, 31 and up leaves only sign bits
	function automatic lpc_pkg::word_t shift_right(input lpc_pkg::word_t a, input logic [16:0] n);
		lpc_pkg::word_t r;
		if (n >= 17'd31)
			r = {32{a[31]}};
		else
			r = a >>> n[4:0];
		return r;
	endfunction

	// Left shift, saturates once a significant bit would be lost
	function automatic lpc_pkg::word_t shift_left_sat(input lpc_pkg::word_t a,
		input logic [16:0] n, output logic ovf);
		logic signed [63:0] wide;
		logic [5:0]         amt;
		lpc_pkg::word_t     r;
		amt  = (n > 17'd32) ? 6'd32 : n[5:0];
		wide = 64'(a) <<< amt;
		ovf  = (wide[63:31] != {33{wide[31]}});
		r    = wide[31:0];
		if (ovf)
			r = a[31] ? 32'sh8000_0000 : 32'sh7fff_ffff;
		return r;
	endfunction

	// Redundant sign bits, i.e. left shifts to normalize
	function automatic lpc_pkg::word_t norm_count(input lpc_pkg::word_t a);
		logic [31:0] x;
		logic        found;
		int          n;
		x = a[31] ? ~a : a;
		found = 1'b0;
		n = 0;
		for (int i = 30; i >= 0; i--)
		begin
			if (!found && x[i])
				found = 1'b1;
			else if (!found)
				n++;
		end
		return (a == '0) ? '0 : 32'(n);
	endfunction

	logic signed [15:0] cnt;
	logic [16:0]        cnt_mag;
	lpc_pkg::word_t     data_c;
	logic               ovf_c;

	// Negate in 17 bits so -32768 keeps its magnitude
	assign cnt     = i_opnd_b[15:0];
	assign cnt_mag = cnt[15] ? -17'(cnt) : 17'(cnt);

	always_comb
	begin
		data_c = i_result;
		ovf_c  = i_ovf;
		case (i_opcode)
			lpc_pkg::OP_L_SHL:
			begin
				ovf_c = 1'b0;
				if (cnt[15])
					data_c = shift_right(i_opnd_a, cnt_mag);
				else
					data_c = shift_left_sat(i_opnd_a, cnt_mag, ovf_c);
			end
			lpc_pkg::OP_L_SHR:
			begin
				ovf_c = 1'b0;
				if (cnt[15])
					data_c = shift_left_sat(i_opnd_a, cnt_mag, ovf_c);
				else
					data_c = shift_right(i_opnd_a, cnt_mag);
			end
			lpc_pkg::OP_NORM_L:
			begin
				ovf_c  = 1'b0;
				data_c = norm_count(i_opnd_a);
			end
			default:
			begin
				data_c = i_result;
				ovf_c  = i_ovf;
			end
		endcase
	end

	//////////////////////////////
	// Writeback registers
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (!i_rst_n)
		begin
			o_wb_valid <= 1'b0;
			o_wb_ovf   <= 1'b0;
		end
		else
		begin
			o_wb_valid <= i_valid;
			o_wb_ovf   <= i_valid & ovf_c;
		end
	end

	always_ff @(posedge clock)
	begin
		o_wb_addr <= i_addr_d;
		o_wb_data <= data_c;
	end

	// Saturated or not, a shift never flips the sign of its operand
	a_shift_keeps_sign: assert property (@(posedge clock) disable iff (!i_rst_n)
		i_valid && (i_opcode == lpc_pkg::OP_L_SHL || i_opcode == lpc_pkg::OP_L_SHR)
		|=> o_wb_valid && o_wb_data[31] == $past(i_opnd_a[31]));

endmodule

`default_nettype wire

//--- source/basic_op_alu.sv
`default_nettype none

module basic_op_alu (
	input  wire                     clock,
	input  wire                     i_rst_n,
	input  wire                     i_valid,
	input  wire lpc_pkg::basic_op_e i_opcode,
	input  wire lpc_pkg::addr_t     i_addr_d,
	input  wire lpc_pkg::word_t     i_opnd_a,
	input  wire lpc_pkg::word_t     i_opnd_b,
	output logic                    o_valid,
	output lpc_pkg::basic_op_e      o_opcode,
	output lpc_pkg::addr_t          o_addr_d,
	output lpc_pkg::word_t          o_result,
	output logic                    o_ovf,
	output lpc_pkg::word_t          o_opnd_a,
	output lpc_pkg::word_t          o_opnd_b
);

	localparam lpc_pkg::word_t WORD_MAX = 32'sh7fff_ffff;
	localparam lpc_pkg::word_t WORD_MIN = 32'sh8000_0000;

	//////////////////////////////
	// Saturation helpers
	//////////////////////////////

	// Clamp to Word16, sign-extended into a full word
	function automatic lpc_pkg::word_t sat16(input logic signed [32:0] v, output logic ovf);
		lpc_pkg::word_t r;
		ovf = 1'b0;
		r = v[31:0];
		if (v > 33'sd32767)
		begin
			r = 32'sd32767;
			ovf = 1'b1;
		end
		else if (v < -33'sd32768)
		begin
			r = -32'sd32768;
			ovf = 1'b1;
		end
		return r;
	endfunction

	// Clamp a 33-bit sum to Word32
	function automatic lpc_pkg::word_t sat32(input logic signed [32:0] v, output logic ovf);
		lpc_pkg::word_t r;
		ovf = (v[32] != v[31]);
		r = v[31:0];
		if (ovf)
			r = v[32] ? WORD_MIN : WORD_MAX;
		return r;
	endfunction

	// Fractional multiply, only -1 * -1 overflows
	function automatic lpc_pkg::word_t l_mult(input logic signed [15:0] x,
		input logic signed [15:0] y, output logic ovf);
		logic signed [31:0] prod;
		lpc_pkg::word_t r;
		prod = x * y;
		ovf = (prod == 32'sh4000_0000);
		r = ovf ? WORD_MAX : {prod[30:0], 1'b0};
		return r;
	endfunction

	logic signed [15:0] lo_a;
	logic signed [15:0] lo_b;
	logic signed [15:0] hi_a;
	logic signed [31:0] prod16;
	lpc_pkg::word_t     result_c;
	lpc_pkg::word_t     mac_prod;
	logic               ovf_c;
	logic               mac_ovf1;
	logic               mac_ovf2;

	assign lo_a   = i_opnd_a[15:0];
	assign lo_b   = i_opnd_b[15:0];
	assign hi_a   = i_opnd_a[31:16];
	assign prod16 = lo_a * lo_b;

	always_comb
	begin
		result_c = i_opnd_a;
		ovf_c    = 1'b0;
		mac_prod = '0;
		mac_ovf1 = 1'b0;
		mac_ovf2 = 1'b0;
		case (i_opcode)
			lpc_pkg::OP_ADD:    result_c = sat16(33'(lo_a) + 33'(lo_b), ovf_c);
			lpc_pkg::OP_SUB:    result_c = sat16(33'(lo_a) - 33'(lo_b), ovf_c);
			lpc_pkg::OP_MULT:   result_c = sat16(33'(prod16 >>> 15), ovf_c);
			lpc_pkg::OP_L_ADD:  result_c = sat32(33'(i_opnd_a) + 33'(i_opnd_b), ovf_c);
			lpc_pkg::OP_L_SUB:  result_c = sat32(33'(i_opnd_a) - 33'(i_opnd_b), ovf_c);
			lpc_pkg::OP_L_MULT: result_c = l_mult(lo_a, lo_b, ovf_c);
			lpc_pkg::OP_L_MAC:
			begin
				// Packed coefficient pair in A, accumulator in B
				mac_prod = l_mult(hi_a, lo_a, mac_ovf1);
				result_c = sat32(33'(i_opnd_b) + 33'(mac_prod), mac_ovf2);
				ovf_c    = mac_ovf1 | mac_ovf2;
			end
			lpc_pkg::OP_L_NEGATE:
			begin
				ovf_c    = (i_opnd_a == WORD_MIN);
				result_c = ovf_c ? WORD_MAX : -i_opnd_a;
			end
			lpc_pkg::OP_L_ABS:
			begin
				ovf_c    = (i_opnd_a == WORD_MIN);
				result_c = ovf_c ? WORD_MAX : (i_opnd_a[31] ? -i_opnd_a : i_opnd_a);
			end
			// Shifts and norm_l finish in stage 3
			default:            result_c = i_opnd_a;
		endcase
	end

	//////////////////////////////
	// Stage 2 registers
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (!i_rst_n)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	always_ff @(posedge clock)
	begin
		o_opcode <= i_opcode;
		o_addr_d <= i_addr_d;
		o_result <= result_c;
		o_ovf    <= ovf_c;
		o_opnd_a <= i_opnd_a;
		o_opnd_b <= i_opnd_b;
	end

	a_legal_opcode: assert property (@(posedge clock) disable iff (!i_rst_n)
		i_valid |-> !$isunknown(i_opcode) && i_opcode <= lpc_pkg::OP_NORM_L);

endmodule

`default_nettype wire

//--- source/op_issue.sv
`default_nettype none

module op_issue (
	input  wire                     clock,
	input  wire                     i_rst_n,
	// Command
	input  wire                     i_op_valid,
	input  wire lpc_pkg::basic_op_e i_opcode,
	input  wire lpc_pkg::addr_t     i_addr_a,
	input  wire lpc_pkg::addr_t     i_addr_b,
	input  wire lpc_pkg::addr_t     i_addr_d,
	// Test port
	input  wire                     i_test_mode,
	input  wire lpc_pkg::addr_t     i_test_addr,
	input  wire                     i_wb_valid,
	// Memory read addresses
	output lpc_pkg::addr_t          o_raddr_a,
	output lpc_pkg::addr_t          o_raddr_b,
	// To stage 2
	output logic                    o_valid,
	output lpc_pkg::basic_op_e      o_opcode,
	output lpc_pkg::addr_t          o_addr_d
);

	// Commands still ahead of their memory write
	localparam int HIST = 3;

	logic [HIST-1:0] hist_valid;
	lpc_pkg::addr_t  hist_addr [HIST];
	logic            uses_b;
	logic            raw_hit;

	// Test port borrows read port A
	assign o_raddr_a = i_test_mode ? i_test_addr : i_addr_a;
	assign o_raddr_b = i_addr_b;

	//////////////////////////////
	// Stage 1 registers
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (!i_rst_n)
			o_valid <= 1'b0;
		else
			o_valid <= i_op_valid;
	end

	always_ff @(posedge clock)
	begin
		o_opcode <= i_opcode;
		o_addr_d <= i_addr_d;
	end

	//////////////////////////////
	// Pending destinations
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (!i_rst_n)
			hist_valid <= '0;
		else
			hist_valid <= {hist_valid[HIST-2:0], i_op_valid};
	end

	always_ff @(posedge clock)
	begin
		hist_addr[0] <= i_addr_d;
		for (int i = 1; i < HIST; i++)
			hist_addr[i] <= hist_addr[i-1];
	end

	// Unary ops never look at operand B
	always_comb
	begin
		case (i_opcode)
			lpc_pkg::OP_L_NEGATE,
			lpc_pkg::OP_L_ABS,
			lpc_pkg::OP_NORM_L: uses_b = 1'b0;
			default:            uses_b = 1'b1;
		endcase
	end

	always_comb
	begin
		raw_hit = 1'b0;
		for (int i = 0; i < HIST; i++)
		begin
			if (hist_valid[i] && (hist_addr[i] == i_addr_a ||
				(uses_b && hist_addr[i] == i_addr_b)))
				raw_hit = 1'b1;
		end
	end

	// No forwarding path exists, software spaces dependent commands
	a_no_raw_hazard: assert property (@(posedge clock) disable iff (!i_rst_n)
		i_op_valid |-> !raw_hit);

	a_no_cmd_in_test: assert property (@(posedge clock) disable iff (!i_rst_n)
		!(i_op_valid && i_test_mode));

	// Raising test mode would steal the write port from a pending result
	a_test_entry_idle: assert property (@(posedge clock) disable iff (!i_rst_n)
		$rose(i_test_mode) |-> !i_wb_valid && hist_valid == '0);

endmodule

`default_nettype wire

//--- source/scratch_memory.sv
`default_nettype none

`include "lpc_defines.svh"

module scratch_memory (
	input  wire                 clock,
	// Write port
	input  wire                 i_we,
	input  wire lpc_pkg::addr_t i_waddr,
	input  wire lpc_pkg::word_t i_wdata,
	// Read ports
	input  wire lpc_pkg::addr_t i_raddr_a,
	input  wire lpc_pkg::addr_t i_raddr_b,
	output lpc_pkg::word_t      o_rdata_a,
	output lpc_pkg::word_t      o_rdata_b
);

	lpc_pkg::word_t mem [0:`LPC_MEM_DEPTH-1];

	//////////////////////////////
	// Write port
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (i_we)
		begin
			mem[i_waddr] <= i_wdata;
		end
	end

	//////////////////////////////
	// Read ports
	//////////////////////////////

	// Nonblocking reads see the array before this edge's write,
	// so a same-address collision returns the old word
	always_ff @(posedge clock)
	begin
		o_rdata_a <= mem[i_raddr_a];
	end

	always_ff @(posedge clock)
	begin
		o_rdata_b <= mem[i_raddr_b];
	end

endmodule

`default_nettype wire

//--- source/lpc_pkg.sv
`default_nettype none

`include "lpc_defines.svh"

package lpc_pkg;

	// Scratch data word, signed fixed point
	typedef logic signed [`LPC_WORD_W-1:0] word_t;

	// Scratch memory address
	typedef logic [`LPC_ADDR_W-1:0] addr_t;

	//////////////////////////////
	// Basic operations
	//////////////////////////////

	typedef enum logic [`LPC_OP_W-1:0] {
		// 16-bit ops on the low halves
		OP_ADD      = 'd0,
		OP_SUB      = 'd1,
		OP_MULT     = 'd2,
		// 32-bit arithmetic
		OP_L_ADD    = 'd3,
		OP_L_SUB    = 'd4,
		OP_L_MULT   = 'd5,
		OP_L_MAC    = 'd6,
		OP_L_NEGATE = 'd7,
		OP_L_ABS    = 'd8,
		// Handled in the shift stage
		OP_L_SHL    = 'd9,
		OP_L_SHR    = 'd10,
		OP_NORM_L   = 'd11
	} basic_op_e;

endpackage

`default_nettype wire

//--- source/lpc_defines.svh
`ifndef LPC_DEFINES_SVH
`define LPC_DEFINES_SVH

//////////////////////////////
// Scratch memory geometry
//////////////////////////////

// Word address into the scratch RAM
`define LPC_ADDR_W 11

// Data word, holds both Word16 and Word32 values
`define LPC_WORD_W 32

// Number of scratch words
`define LPC_MEM_DEPTH 2048

//////////////////////////////
// Command encoding
//////////////////////////////

`define LPC_OP_W 4

`endif
